// File: logic/exe_isa_pkg.sv
`default_nettype none

package exe_isa_pkg;

    // bit positions in the one-hot alu view
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_e;

    // unit that produces the result
    typedef enum logic [1:0] {
        unit_alu = 2'd0,
        unit_mul = 2'd1,
        unit_div = 2'd2
    } op_class_e;

    typedef enum logic [1:0] {
        mul_w   = 2'd0,
        mulh_w  = 2'd1,
        mulh_wu = 2'd2
    } mul_kind_e;

    typedef enum logic [1:0] {
        div_w  = 2'd0,
        mod_w  = 2'd1,
        div_wu = 2'd2,
        mod_wu = 2'd3
    } div_kind_e;

    typedef struct packed {
        logic [7:0] pad;
        mul_kind_e  mul_kind;
        div_kind_e  div_kind;
    } md_kind_t;

    // op_class picks which view is meaningful
    typedef union packed {
        logic [11:0] alu_onehot;
        md_kind_t    md;
    } exe_op_u;

endpackage

`default_nettype wire

// File: logic/exe_bus_pkg.sv
`default_nettype none

package exe_bus_pkg;

    import exe_isa_pkg::*;

    typedef enum logic [3:0] {
        mem_none = 4'd0,
        ld_b     = 4'd1,
        ld_h     = 4'd2,
        ld_w     = 4'd3,
        ld_bu    = 4'd4,
        ld_hu    = 4'd5,
        st_b     = 4'd6,
        st_h     = 4'd7,
        st_w     = 4'd8
    } mem_kind_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rj_value;
        logic [31:0] rkd_value;
        logic [31:0] imm;
        logic        src1_is_pc;
        logic        src2_is_imm;
        exe_op_u     op;
        op_class_e   op_class;
        logic        gr_we;
        logic [4:0]  dest;
        mem_kind_e   mem_kind;
    } ds_to_es_t;

    // load kind rides along for the memory stage to align data
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic        gr_we;
        logic [4:0]  dest;
        logic        res_from_mem;
        mem_kind_e   mem_kind;
    } es_to_ms_t;

endpackage

`default_nettype wire

// File: logic/exe_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exe_alu
    import exe_isa_pkg::*;
(
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    input  exe_op_u     op,
    input  op_class_e   op_class,
    output logic [31:0] result
);

    logic [11:0]        onehot;
    logic               do_sub;
    logic [31:0]        adder_b;
    logic [32:0]        adder_out;
    logic [31:0]        sum;
    logic               slt_res;
    logic               sltu_res;
    logic [31:0]        sll_res;
    logic [31:0]        srl_res;
    logic [31:0]        sra_res;
    logic [31:0]        alu_res;
    logic               mul_signed;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] product;
    logic [31:0]        mul_res;

    assign onehot = op.alu_onehot;

    // sub and both compares reuse the adder with src2 inverted
    assign do_sub    = onehot[alu_sub] | onehot[alu_slt] | onehot[alu_sltu];
    assign adder_b   = do_sub ? ~src2 : src2;
    assign adder_out = {1'b0, src1} + {1'b0, adder_b} + {32'd0, do_sub};
    assign sum       = adder_out[31:0];

    assign slt_res  = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & sum[31]);
    // no carry out means a borrow
    assign sltu_res = ~adder_out[32];

    assign sll_res = src1 << src2[4:0];
    assign srl_res = src1 >> src2[4:0];
    assign sra_res = $signed(src1) >>> src2[4:0];

    assign alu_res = ({32{onehot[alu_add] | onehot[alu_sub]}} & sum)
                   | ({32{onehot[alu_slt]}}  & {31'd0, slt_res})
                   | ({32{onehot[alu_sltu]}} & {31'd0, sltu_res})
                   | ({32{onehot[alu_and]}}  & (src1 & src2))
                   | ({32{onehot[alu_nor]}}  & ~(src1 | src2))
                   | ({32{onehot[alu_or]}}   & (src1 | src2))
                   | ({32{onehot[alu_xor]}}  & (src1 ^ src2))
                   | ({32{onehot[alu_sll]}}  & sll_res)
                   | ({32{onehot[alu_srl]}}  & srl_res)
                   | ({32{onehot[alu_sra]}}  & sra_res)
                   | ({32{onehot[alu_lui]}}  & src2);

    // 33-bit operands cover both signed and unsigned high halves
    assign mul_signed = (op.md.mul_kind == mulh_w);
    assign mul_a      = {mul_signed & src1[31], src1};
    assign mul_b      = {mul_signed & src2[31], src2};
    assign product    = mul_a * mul_b;
    assign mul_res    = (op.md.mul_kind == mul_w) ? product[31:0] : product[63:32];

    assign result = (op_class == unit_mul) ? mul_res : alu_res;

endmodule

`default_nettype wire

// File: logic/exe_divider.sv
`timescale 1ns/10ps
`default_nettype none

module exe_divider
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        cancel,
    input  logic        is_signed,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic        busy,
    output logic        done,
    output logic [31:0] quotient,
    output logic [31:0] remainder
);

    logic        launch;
    logic        loading;
    logic        iterate;
    logic [4:0]  count;
    logic        signed_r;
    logic        neg_q;
    logic        neg_r;
    logic [31:0] quo;
    logic [31:0] rem;
    logic [31:0] dsr;
    logic [31:0] abs_dividend;
    logic [31:0] abs_divisor;
    logic [32:0] partial;
    logic [33:0] trial;
    logic        fits;

    assign launch  = start && !busy && !cancel;
    assign iterate = busy && !loading && !done;

    // quo and dsr still hold the raw operands while loading
    assign abs_dividend = (signed_r && quo[31]) ? -quo : quo;
    assign abs_divisor  = (signed_r && dsr[31]) ? -dsr : dsr;

    // shift in the next dividend bit, then try the subtract
    assign partial = {rem, quo[31]};
    assign trial   = {1'b0, partial} - {2'b00, dsr};
    assign fits    = ~trial[33];

    always_ff @(posedge clk)
    begin
        if (reset || cancel)
        begin
            busy    <= 1'b0;
            loading <= 1'b0;
            done    <= 1'b0;
            count   <= 5'd0;
        end
        else if (launch)
        begin
            busy    <= 1'b1;
            loading <= 1'b1;
            count   <= 5'd0;
        end
        else if (loading)
        begin
            loading <= 1'b0;
        end
        else if (done)
        begin
            done <= 1'b0;
            busy <= 1'b0;
        end
        else if (busy)
        begin
            count <= count + 5'd1;
            if (count == 5'd31)
            begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            quo      <= dividend;
            dsr      <= divisor;
            signed_r <= is_signed;
        end
        else if (loading)
        begin
            // a zero divisor keeps the all-ones quotient unsigned
            neg_q <= signed_r && (quo[31] ^ dsr[31]) && (dsr != 32'd0);
            neg_r <= signed_r && quo[31];
            quo   <= abs_dividend;
            dsr   <= abs_divisor;
            rem   <= 32'd0;
        end
        else if (iterate)
        begin
            rem <= fits ? trial[31:0] : partial[31:0];
            quo <= {quo[30:0], fits};
        end
    end

    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;

endmodule

`default_nettype wire

// File: logic/exe_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exe_stage
    import exe_isa_pkg::*;
    import exe_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ms_allowin,
    output logic        es_allowin,
    input  logic        ds_to_es_valid,
    input  ds_to_es_t   ds_to_es_bus,
    output logic        es_to_ms_valid,
    output es_to_ms_t   es_to_ms_bus,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    output logic        es_valid_out,
    input  logic        wb_ex
);

    logic        es_valid;
    ds_to_es_t   es_bus;
    logic        es_ready_go;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;
    logic        is_div;
    div_kind_e   div_kind;
    logic        div_signed;
    logic        div_start;
    logic        div_busy;
    logic        div_done;
    logic [31:0] div_quotient;
    logic [31:0] div_remainder;
    logic [31:0] div_result;
    logic        div_started;
    logic        div_held;
    logic        is_load;
    logic        is_store;
    logic [3:0]  st_mask;

    always_ff @(posedge clk)
    begin
        if (reset || wb_ex)
        begin
            es_valid <= 1'b0;
        end
        else if (es_allowin)
        begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ds_to_es_valid && es_allowin && !wb_ex)
        begin
            es_bus <= ds_to_es_bus;
        end
    end

    assign src1 = es_bus.src1_is_pc ? es_bus.pc : es_bus.rj_value;
    assign src2 = es_bus.src2_is_imm ? es_bus.imm : es_bus.rkd_value;

    exe_alu i_alu (
        .src1     (src1),
        .src2     (src2),
        .op       (es_bus.op),
        .op_class (es_bus.op_class),
        .result   (alu_result)
    );

    assign is_div     = (es_bus.op_class == unit_div);
    assign div_kind   = es_bus.op.md.div_kind;
    assign div_signed = (div_kind == div_w) || (div_kind == mod_w);
    // one launch per item
    assign div_start  = es_valid && is_div && !div_started && !div_busy;

    exe_divider i_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .cancel    (wb_ex),
        .is_signed (div_signed),
        .dividend  (src1),
        .divisor   (src2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    always_ff @(posedge clk)
    begin
        if (reset || wb_ex || es_allowin)
        begin
            div_started <= 1'b0;
            div_held    <= 1'b0;
        end
        else
        begin
            if (div_start)
            begin
                div_started <= 1'b1;
            end
            if (div_done)
            begin
                div_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (div_done)
        begin
            div_result <= (div_kind == mod_w || div_kind == mod_wu) ? div_remainder
                                                                    : div_quotient;
        end
    end

    assign es_ready_go    = !is_div || div_held;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_valid_out   = es_valid;

    assign is_load  = es_bus.mem_kind inside {ld_b, ld_h, ld_w, ld_bu, ld_hu};
    assign is_store = es_bus.mem_kind inside {st_b, st_h, st_w};

    always_comb
    begin
        es_to_ms_bus.pc           = es_bus.pc;
        es_to_ms_bus.result       = is_div ? div_result : alu_result;
        es_to_ms_bus.gr_we        = es_bus.gr_we;
        es_to_ms_bus.dest         = es_bus.dest;
        es_to_ms_bus.res_from_mem = is_load;
        es_to_ms_bus.mem_kind     = es_bus.mem_kind;
    end

    // byte lanes follow the low address bits
    always_comb
    begin
        case (es_bus.mem_kind)
            st_b:
            begin
                st_mask         = 4'b0001 << data_sram_addr[1:0];
                data_sram_wdata = {4{es_bus.rkd_value[7:0]}};
            end
            st_h:
            begin
                st_mask         = 4'b0011 << {data_sram_addr[1], 1'b0};
                data_sram_wdata = {2{es_bus.rkd_value[15:0]}};
            end
            st_w:
            begin
                st_mask         = 4'b1111;
                data_sram_wdata = es_bus.rkd_value;
            end
            default:
            begin
                st_mask         = 4'b0000;
                data_sram_wdata = es_bus.rkd_value;
            end
        endcase
    end

    assign data_sram_addr = alu_result;
    assign data_sram_en   = es_valid && (is_load || is_store);
    assign data_sram_we   = (es_valid && is_store) ? st_mask : 4'b0000;

endmodule

`default_nettype wire

// File: dv/exe_stage_properties.sv
`timescale 1ns/10ps
`default_nettype none

module exe_stage_properties
    import exe_bus_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        wb_ex,
    input logic        ms_allowin,
    input logic        es_valid_out,
    input logic        es_to_ms_valid,
    input es_to_ms_t   es_to_ms_bus,
    input logic        data_sram_en,
    input logic [3:0]  data_sram_we,
    input logic [31:0] data_sram_addr,
    input logic [31:0] data_sram_wdata,
    input logic        div_busy,
    input logic        div_done
);

    int unsigned fail_count = 0;
    logic        store_valid;

    assign store_valid = es_valid_out && (es_to_ms_bus.mem_kind inside {st_b, st_h, st_w});

    valid_after_reset: assert property (@(posedge clk) reset |=> !es_to_ms_valid)
    else
    begin
        fail_count++;
        $error("es_to_ms_valid high after a reset edge");
    end

    // a stalled item must not change under the memory stage
    hold_when_stalled: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin && !wb_ex |=> $stable(es_to_ms_bus)
            && $stable(data_sram_en) && $stable(data_sram_we)
            && $stable(data_sram_addr) && $stable(data_sram_wdata))
    else
    begin
        fail_count++;
        $error("outputs changed while the stage was stalled");
    end

    no_write_without_store: assert property (@(posedge clk) disable iff (reset)
        !store_valid |-> data_sram_we == 4'b0000)
    else
    begin
        fail_count++;
        $error("byte write enable without a valid store");
    end

    done_only_busy: assert property (@(posedge clk) disable iff (reset) div_done |-> div_busy)
    else
    begin
        fail_count++;
        $error("divider done while idle");
    end

endmodule

`default_nettype wire

// File: dv/exe_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exe_stage_tb
    import exe_isa_pkg::*;
    import exe_bus_pkg::*;
();

    localparam int num_items  = 400;
    localparam int max_cycles = num_items * 35 * 2;

    typedef struct packed {
        es_to_ms_t   bus;
        logic        sram_en;
        logic [3:0]  sram_we;
        logic [31:0] sram_addr;
        logic [31:0] sram_wdata;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        ms_allowin;
    logic        es_allowin;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es_bus;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms_bus;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic        es_valid_out;
    logic        wb_ex;

    logic [31:0] lcg_state = 32'hc764_2730;
    expect_t     exp_q[$];
    int          accepted = 0;
    int          checked = 0;
    int          flushed = 0;
    int          errors = 0;
    int          cycles = 0;
    int          first_random = 0;

    exe_stage i_dut (.*);

    bind exe_stage exe_stage_properties i_props (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // low state bits cycle quickly, so hand back the high half first
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] corner(input logic [31:0] x);
        if (x[31:29] != 3'd0)
            return x;
        case (x[2:0])
            3'd0: return 32'd0;
            3'd1: return 32'd1;
            3'd2: return 32'hffff_ffff;
            3'd3: return 32'h8000_0000;
            3'd4: return 32'h7fff_ffff;
            default: return x;
        endcase
    endfunction

    function automatic ds_to_es_t md_instr(input op_class_e cls, input logic [1:0] kind,
                                           input logic [31:0] a, input logic [31:0] b);
        ds_to_es_t d;
        d           = '0;
        d.pc        = 32'h1c00_0000;
        d.op_class  = cls;
        d.rj_value  = a;
        d.rkd_value = b;
        d.gr_we     = 1'b1;
        d.dest      = 5'd4;
        if (cls == unit_mul)
            d.op.md.mul_kind = mul_kind_e'(kind);
        else
            d.op.md.div_kind = div_kind_e'(kind);
        return d;
    endfunction

    function automatic ds_to_es_t mem_instr(input mem_kind_e kind, input logic [31:0] addr);
        ds_to_es_t d;
        d               = '0;
        d.pc            = 32'h1c00_0100;
        d.op.alu_onehot = 12'd1 << alu_add;
        d.src2_is_imm   = 1'b1;
        d.rj_value      = next_rand();
        d.rkd_value     = next_rand();
        d.imm           = addr - d.rj_value;
        d.gr_we         = kind inside {ld_b, ld_h, ld_w, ld_bu, ld_hu};
        d.dest          = 5'd7;
        d.mem_kind      = kind;
        return d;
    endfunction

    function automatic ds_to_es_t random_instr();
        ds_to_es_t   d;
        logic [31:0] pick;
        mem_kind_e   kind;
        logic [31:0] mask;
        pick          = next_rand();
        d             = '0;
        d.pc          = next_rand() & 32'hffff_fffc;
        d.rj_value    = corner(next_rand());
        d.rkd_value   = corner(next_rand());
        d.imm         = next_rand();
        d.src1_is_pc  = pick[0];
        d.src2_is_imm = pick[1];
        d.gr_we       = pick[2];
        d.dest        = pick[7:3];
        case (pick[9:8])
            2'd0: d.op.alu_onehot = 12'd1 << (pick[13:10] % 12);
            2'd1:
            begin
                d.op_class       = unit_mul;
                d.op.md.mul_kind = (pick[11:10] == 2'd3) ? mul_w : mul_kind_e'(pick[11:10]);
            end
            2'd2:
            begin
                d.op_class       = unit_div;
                d.op.md.div_kind = div_kind_e'(pick[11:10]);
            end
            default:
            begin
                kind = mem_kind_e'(4'd1 + {1'b0, pick[12:10]});
                mask = (kind inside {ld_w, st_w}) ? 32'd3
                     : (kind inside {ld_h, ld_hu, st_h}) ? 32'd1 : 32'd0;
                d    = mem_instr(kind, next_rand() & ~mask);
            end
        endcase
        return d;
    endfunction

    function automatic logic [31:0] divide(input logic [31:0] a, input logic [31:0] b,
                                           input div_kind_e k);
        logic        sgn;
        logic [31:0] q;
        logic [31:0] r;
        sgn = (k == div_w) || (k == mod_w);
        if (b == 32'd0)
        begin
            q = 32'hffff_ffff;
            r = a;
        end
        else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff)
        begin
            q = a;
            r = 32'd0;
        end
        else if (sgn)
        begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        else
        begin
            q = a / b;
            r = a % b;
        end
        return (k == mod_w || k == mod_wu) ? r : q;
    endfunction

    function automatic expect_t model(input ds_to_es_t d);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [63:0] prod;
        logic        sgn;
        e   = '0;
        a   = d.src1_is_pc ? d.pc : d.rj_value;
        b   = d.src2_is_imm ? d.imm : d.rkd_value;
        res = 32'd0;
        if (d.op_class == unit_mul)
        begin
            sgn  = (d.op.md.mul_kind == mulh_w);
            prod = {{32{sgn & a[31]}}, a} * {{32{sgn & b[31]}}, b};
            res  = (d.op.md.mul_kind == mul_w) ? prod[31:0] : prod[63:32];
        end
        else if (d.op_class == unit_div)
        begin
            res = divide(a, b, d.op.md.div_kind);
        end
        else
        begin
            case (1'b1)
                d.op.alu_onehot[alu_add]:  res = a + b;
                d.op.alu_onehot[alu_sub]:  res = a - b;
                d.op.alu_onehot[alu_slt]:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                d.op.alu_onehot[alu_sltu]: res = (a < b) ? 32'd1 : 32'd0;
                d.op.alu_onehot[alu_and]:  res = a & b;
                d.op.alu_onehot[alu_nor]:  res = ~(a | b);
                d.op.alu_onehot[alu_or]:   res = a | b;
                d.op.alu_onehot[alu_xor]:  res = a ^ b;
                d.op.alu_onehot[alu_sll]:  res = a << b[4:0];
                d.op.alu_onehot[alu_srl]:  res = a >> b[4:0];
                d.op.alu_onehot[alu_sra]:  res = $signed(a) >>> b[4:0];
                d.op.alu_onehot[alu_lui]:  res = b;
                default:                   res = 32'd0;
            endcase
        end
        e.bus.pc           = d.pc;
        e.bus.result       = res;
        e.bus.gr_we        = d.gr_we;
        e.bus.dest         = d.dest;
        e.bus.res_from_mem = d.mem_kind inside {ld_b, ld_h, ld_w, ld_bu, ld_hu};
        e.bus.mem_kind     = d.mem_kind;
        e.sram_en          = (d.mem_kind != mem_none);
        e.sram_addr        = a + b;
        case (d.mem_kind)
            st_b:
            begin
                e.sram_we    = 4'b0001 << e.sram_addr[1:0];
                e.sram_wdata = {4{d.rkd_value[7:0]}};
            end
            st_h:
            begin
                e.sram_we    = e.sram_addr[1] ? 4'b1100 : 4'b0011;
                e.sram_wdata = {2{d.rkd_value[15:0]}};
            end
            st_w:
            begin
                e.sram_we    = 4'b1111;
                e.sram_wdata = d.rkd_value;
            end
            default:
            begin
                e.sram_we = 4'b0000;
            end
        endcase
        return e;
    endfunction

    // sampled on the rising edge before the DUT registers update
    always @(posedge clk)
    begin
        expect_t e;
        cycles++;
        if (!reset)
        begin
            // the stage holds exactly the items the model still expects
            assert (es_valid_out == (exp_q.size() != 0)
                    && es_allowin == (exp_q.size() == 0 || (es_to_ms_valid && ms_allowin)))
            else
            begin
                errors++;
                $display("Fail %0d ns: valid %b allowin %b with %0d items held",
                         $time, es_valid_out, es_allowin, exp_q.size());
            end
        end
        if (!reset && wb_ex && es_valid_out)
        begin
            void'(exp_q.pop_front());
            flushed++;
        end
        else if (!reset && es_to_ms_valid && ms_allowin)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("an item left the stage at %0d ns with nothing expected", $time);
            end
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                checked++;
                assert (es_to_ms_bus == e.bus)
                else
                begin
                    errors++;
                    $display("Fail %0d ns: pc %h result %h expected %h, bus %h expected %h",
                             $time, e.bus.pc, es_to_ms_bus.result, e.bus.result,
                             es_to_ms_bus, e.bus);
                end
                assert (data_sram_en == e.sram_en && data_sram_we == e.sram_we
                        && (!e.sram_en || data_sram_addr == e.sram_addr)
                        && (e.sram_we == 4'd0 || data_sram_wdata == e.sram_wdata))
                else
                begin
                    errors++;
                    $display("Fail %0d ns: sram en %b we %b addr %h data %h, expected %b %b %h %h",
                             $time, data_sram_en, data_sram_we, data_sram_addr, data_sram_wdata,
                             e.sram_en, e.sram_we, e.sram_addr, e.sram_wdata);
                end
            end
        end
        if (!reset && ds_to_es_valid && es_allowin && !wb_ex)
        begin
            exp_q.push_back(model(ds_to_es_bus));
            accepted++;
        end
    end

    initial
    begin
        while (cycles < max_cycles)
            @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d items accepted", cycles, accepted,
                 num_items);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        ds_to_es_t stim_q[$];
        clk            = 1'b0;
        reset          = 1'b1;
        ms_allowin     = 1'b0;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        wb_ex          = 1'b0;

        stim_q.push_back(md_instr(unit_mul, mul_w, 32'hffff_ffff, 32'hffff_ffff));
        stim_q.push_back(md_instr(unit_mul, mulh_w, 32'hffff_fffd, 32'hffff_fffb));
        stim_q.push_back(md_instr(unit_mul, mulh_wu, 32'hffff_ffff, 32'hffff_ffff));
        stim_q.push_back(md_instr(unit_mul, mulh_w, 32'h8000_0000, 32'h8000_0000));
        stim_q.push_back(md_instr(unit_div, div_w, 32'h8000_0000, 32'hffff_ffff));
        stim_q.push_back(md_instr(unit_div, mod_w, 32'h8000_0000, 32'hffff_ffff));
        stim_q.push_back(md_instr(unit_div, div_w, 32'h1234_5678, 32'd0));
        stim_q.push_back(md_instr(unit_div, mod_w, 32'h8765_4321, 32'd0));
        stim_q.push_back(md_instr(unit_div, div_wu, 32'hdead_beef, 32'd0));
        stim_q.push_back(md_instr(unit_div, mod_wu, 32'hdead_beef, 32'd0));
        stim_q.push_back(md_instr(unit_div, div_w, 32'hffff_fff9, 32'd2));
        for (int off = 0; off < 4; off++)
        begin
            stim_q.push_back(mem_instr(st_b, 32'h0000_1000 + off));
            if (off % 2 == 0)
                stim_q.push_back(mem_instr(st_h, 32'h0000_2000 + off));
        end
        stim_q.push_back(mem_instr(st_w, 32'h0000_3000));
        stim_q.push_back(mem_instr(ld_bu, 32'h0000_3003));
        first_random = stim_q.size();
        while (stim_q.size() < num_items)
            stim_q.push_back(random_instr());

        repeat (8) @(negedge clk);
        reset = 1'b0;

        // flushes start only once the directed items are through
        while (accepted < num_items || exp_q.size() != 0)
        begin
            @(negedge clk);
            ms_allowin     = next_rand() % 4 != 0;
            wb_ex          = es_valid_out && accepted > first_random && next_rand() % 128 == 0;
            ds_to_es_valid = !wb_ex && accepted < num_items && next_rand() % 4 != 0;
            if (accepted < num_items)
                ds_to_es_bus = stim_q[accepted];
        end
        @(negedge clk);
        ds_to_es_valid = 1'b0;
        wb_ex          = 1'b0;
        repeat (2) @(posedge clk);

        $display("checked %0d, flushed %0d, errors %0d, assertion failures %0d",
                 checked, flushed, errors, i_dut.i_props.fail_count);
        if (errors == 0 && i_dut.i_props.fail_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/exe_isa_pkg.sv
logic/exe_bus_pkg.sv
logic/exe_alu.sv
logic/exe_divider.sv
logic/exe_stage.sv
dv/exe_stage_properties.sv
dv/exe_stage_tb.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - files:
      - logic/exe_isa_pkg.sv
      - logic/exe_bus_pkg.sv
      - logic/exe_alu.sv
      - logic/exe_divider.sv
      - logic/exe_stage.sv
  - target: test
    files:
      - dv/exe_stage_properties.sv
      - dv/exe_stage_tb.sv
